// File: hdl/decode_ctrl.sv
// Instruction decoder
module decode_ctrl (
    input  id_pkg::word_t     instr,
    output id_pkg::ctrl_t     ctrl,
    output id_pkg::reg_idx_t  rd_reg_1,  // Register file port 1 select
    output id_pkg::reg_idx_t  rd_reg_2,  // Register file port 2 select
    output logic              use_1,     // Port 1 value really needed
    output logic              use_2,     // Port 2 value really needed
    output id_pkg::dest_tag_t dest,
    output id_pkg::word_t     imm
);

    id_pkg::opcode_t  opcode;
    id_pkg::reg_idx_t field_rd;   // Instr[11:8]
    id_pkg::reg_idx_t field_rs;   // Instr[7:4]
    id_pkg::reg_idx_t field_rt;   // Instr[3:0]
    id_pkg::word_t    imm_arith;  // 4-bit ADDI field, extended
    id_pkg::word_t    imm_mem;    // 8-bit LW/SW/BR field, extended

    assign opcode   = instr[15:12];
    assign field_rd = instr[11:8];
    assign field_rs = instr[7:4];
    assign field_rt = instr[3:0];

    // Sign extension
    assign imm_arith = {{12{instr[3]}}, instr[3:0]};
    assign imm_mem   = {{8{instr[7]}}, instr[7:0]};

    always_comb begin
        // No-op defaults, ports parked on r0
        ctrl     = '0;
        rd_reg_1 = '0;
        rd_reg_2 = '0;
        use_1    = 1'b0;
        use_2    = 1'b0;
        dest     = '0;
        imm      = '0;

        case (opcode)
            id_pkg::OP_ADD, id_pkg::OP_SUB, id_pkg::OP_AND, id_pkg::OP_OR: begin
                rd_reg_1       = field_rs;
                rd_reg_2       = field_rt;
                use_1          = 1'b1;
                use_2          = 1'b1;
                dest           = '{valid: 1'b1, idx: field_rd};
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = id_pkg::alu_op_t'(opcode[2:0]); // Same encoding
            end
            id_pkg::OP_ADDI: begin
                rd_reg_1       = field_rs;
                use_1          = 1'b1;
                dest           = '{valid: 1'b1, idx: field_rd};
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = id_pkg::ALU_ADD;
                imm            = imm_arith;
            end
            id_pkg::OP_LW: begin
                rd_reg_1        = id_pkg::REG_DS;   // Base address
                use_1           = 1'b1;
                dest            = '{valid: 1'b1, idx: field_rd};
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = id_pkg::ALU_ADD;  // DS + offset
                imm             = imm_mem;
            end
            id_pkg::OP_SW: begin
                rd_reg_1        = id_pkg::REG_DS;
                rd_reg_2        = field_rd;         // Store data
                use_1           = 1'b1;
                use_2           = 1'b1;
                ctrl.reg_to_mem = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = id_pkg::ALU_ADD;
                imm             = imm_mem;
            end
            id_pkg::OP_BR: begin
                ctrl.branch = 1'b1;  // Condition travels in branch_cond
                imm         = imm_mem; // PC-relative offset
            end
            id_pkg::OP_CALL: begin
                rd_reg_1       = id_pkg::REG_SP;
                use_1          = 1'b1;
                dest           = '{valid: 1'b1, idx: id_pkg::REG_SP};
                ctrl.reg_write = 1'b1;
                ctrl.call      = 1'b1;
                ctrl.alu_op    = id_pkg::ALU_SUB; // Push, SP - 1
                imm            = 16'd1;
            end
            id_pkg::OP_RET: begin
                rd_reg_1       = id_pkg::REG_SP;
                use_1          = 1'b1;
                dest           = '{valid: 1'b1, idx: id_pkg::REG_SP};
                ctrl.reg_write = 1'b1;
                ctrl.ret       = 1'b1;
                ctrl.alu_op    = id_pkg::ALU_ADD; // Pop, SP + 1
                imm            = 16'd1;
            end
            default: begin
                // Unused opcode, leave the no-op defaults
            end
        endcase
    end

endmodule

// File: hdl/hazard_detect.sv
// Read-after-write hazard check
module hazard_detect (
    input  id_pkg::reg_idx_t  rd_reg_1,
    input  id_pkg::reg_idx_t  rd_reg_2,
    input  logic              use_1,
    input  logic              use_2,
    input  id_pkg::dest_tag_t id_ex_dest,   // One stage ahead
    input  id_pkg::dest_tag_t ex_mem_dest,  // Two stages ahead
    input  id_pkg::dest_tag_t mem_wb_dest,  // Being written back now
    output logic              stall
);

    logic hit_1; // Port 1 source still pending
    logic hit_2; // Port 2 source still pending

    // Source index matches a valid destination tag
    function automatic logic tag_hit(
        input id_pkg::reg_idx_t  idx,
        input id_pkg::dest_tag_t tag
    );
        return tag.valid && (tag.idx == idx);
    endfunction

    // Any of the three younger stages still owes this register
    function automatic logic pending(
        input id_pkg::reg_idx_t  idx,
        input id_pkg::dest_tag_t id_ex_tag,
        input id_pkg::dest_tag_t ex_mem_tag,
        input id_pkg::dest_tag_t mem_wb_tag
    );
        return tag_hit(idx, id_ex_tag)
            || tag_hit(idx, ex_mem_tag)
            || tag_hit(idx, mem_wb_tag); // Read would see the old value
    endfunction

    assign hit_1 = use_1 && pending(rd_reg_1, id_ex_dest, ex_mem_dest, mem_wb_dest);
    assign hit_2 = use_2 && pending(rd_reg_2, id_ex_dest, ex_mem_dest, mem_wb_dest);

    // Every hit holds the instruction back since nothing is forwarded
    assign stall = hit_1 || hit_2;

    // An instruction that reads nothing has nothing to wait for
    no_use_stall: assert final (!stall || use_1 || use_2)
        else $error("hazard_detect: stall without a used source");

endmodule

// File: hdl/id_ex_reg.sv
// ID/EX pipeline register
module id_ex_reg (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,     // Load a bubble instead of next
    input  id_pkg::id_ex_t    next,
    output id_pkg::id_ex_t    id_ex,
    output id_pkg::dest_tag_t held_dest  // Back to the hazard check
);

    always_ff @(posedge clk) begin
        if (rst || stall) begin
            id_ex <= '0; // Bubble with ctrl off and dest invalid
        end else begin
            id_ex <= next;
        end
    end

    assign held_dest = id_ex.dest;

    // Bubble must not do anything downstream
    bubble_is_inert: assert property (
        @(posedge clk) (rst || stall) |=> (id_ex.ctrl == '0 && !id_ex.dest.valid)
    ) else $error("id_ex_reg: bubble carries control or a valid dest");

    // Hazard tags and write enables have to agree
    // or later stages stall on registers nobody writes
    dest_tracks_write: assert property (
        @(posedge clk) disable iff (rst)
        id_ex.dest.valid == id_ex.ctrl.reg_write
    ) else $error("id_ex_reg: dest valid and reg_write disagree");

endmodule

// File: hdl/id_pkg.sv
// Decode stage shared types
package id_pkg;

    // Data and address widths
    typedef logic [15:0] word_t;     // Data word or program counter
    typedef logic [3:0]  reg_idx_t;  // Register file index
    typedef logic [3:0]  opcode_t;   // Instr[15:12]
    typedef logic [2:0]  alu_op_t;   // ALU operation code

    // Opcodes, anything above OP_RET is a no-op
    localparam opcode_t OP_ADD  = 4'd0;
    localparam opcode_t OP_SUB  = 4'd1;
    localparam opcode_t OP_AND  = 4'd2;
    localparam opcode_t OP_OR   = 4'd3;
    localparam opcode_t OP_ADDI = 4'd4;
    localparam opcode_t OP_LW   = 4'd5;
    localparam opcode_t OP_SW   = 4'd6;
    localparam opcode_t OP_BR   = 4'd7;
    localparam opcode_t OP_CALL = 4'd8;
    localparam opcode_t OP_RET  = 4'd9;

    // ALU codes, first four line up with the R-type opcodes
    localparam alu_op_t ALU_ADD  = 3'd0;
    localparam alu_op_t ALU_SUB  = 3'd1;
    localparam alu_op_t ALU_AND  = 3'd2;
    localparam alu_op_t ALU_OR   = 3'd3;
    localparam alu_op_t ALU_PASS = 3'd4;

    // Dedicated registers
    localparam reg_idx_t REG_DS = 4'd14; // Data segment base
    localparam reg_idx_t REG_SP = 4'd15; // Stack pointer

    // Register a later stage is going to write
    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
    } dest_tag_t;

    // Control word carried down the pipe
    typedef struct packed {
        logic    mem_to_reg;  // Load result to register
        logic    reg_to_mem;  // Store register to memory
        logic    reg_write;   // Write-back enable
        logic    alu_src;     // ALU operand B from imm
        alu_op_t alu_op;
        logic    branch;
        logic    call;
        logic    ret;
    } ctrl_t;

    // ID/EX pipeline register contents
    typedef struct packed {
        ctrl_t       ctrl;
        word_t       read_data_1;
        word_t       read_data_2;
        word_t       imm;          // Already sign extended
        dest_tag_t   dest;
        logic [2:0]  branch_cond;  // Instr[10:8]
        logic [11:0] call_target;  // Instr[11:0]
        word_t       pc;
    } id_ex_t;

endpackage

// File: hdl/id_stage.sv
// Instruction decode stage
module id_stage #(
    parameter id_pkg::word_t SP_RESET = '1 // Stack pointer after reset
) (
    input  logic              clk,
    input  logic              rst,
    input  id_pkg::word_t     instr,       // From fetch
    input  id_pkg::word_t     pc,
    input  logic              wb_en,       // From write-back
    input  id_pkg::reg_idx_t  wb_reg,
    input  id_pkg::word_t     wb_data,
    input  id_pkg::dest_tag_t ex_mem_dest,
    input  id_pkg::dest_tag_t mem_wb_dest,
    output id_pkg::id_ex_t    id_ex,
    output logic              stall        // Fetch holds instr and pc
);

    id_pkg::ctrl_t     dec_ctrl;
    id_pkg::reg_idx_t  rd_reg_1;
    id_pkg::reg_idx_t  rd_reg_2;
    logic              use_1;
    logic              use_2;
    id_pkg::dest_tag_t dec_dest;
    id_pkg::word_t     dec_imm;
    id_pkg::word_t     read_data_1;
    id_pkg::word_t     read_data_2;
    id_pkg::dest_tag_t held_dest;   // Dest sitting in ID/EX
    id_pkg::id_ex_t    next;

    reg_file #(.SP_RESET(SP_RESET)) u_reg_file (
        .clk(clk), .rst(rst),
        .wr_en(wb_en), .wr_reg(wb_reg), .wr_data(wb_data),
        .rd_reg_1(rd_reg_1), .rd_reg_2(rd_reg_2),
        .rd_data_1(read_data_1), .rd_data_2(read_data_2)
    );

    decode_ctrl u_decode (
        .instr(instr), .ctrl(dec_ctrl),
        .rd_reg_1(rd_reg_1), .rd_reg_2(rd_reg_2),
        .use_1(use_1), .use_2(use_2),
        .dest(dec_dest), .imm(dec_imm)
    );

    hazard_detect u_hazard (
        .rd_reg_1(rd_reg_1), .rd_reg_2(rd_reg_2),
        .use_1(use_1), .use_2(use_2),
        .id_ex_dest(held_dest), .ex_mem_dest(ex_mem_dest),
        .mem_wb_dest(mem_wb_dest), .stall(stall)
    );

    // Next ID/EX contents
    assign next.ctrl        = dec_ctrl;
    assign next.read_data_1 = read_data_1;
    assign next.read_data_2 = read_data_2;
    assign next.imm         = dec_imm;
    assign next.dest        = dec_dest;
    assign next.branch_cond = instr[10:8];  // BR condition code
    assign next.call_target = instr[11:0];  // CALL absolute target
    assign next.pc          = pc;

    id_ex_reg u_id_ex (
        .clk(clk), .rst(rst), .stall(stall),
        .next(next), .id_ex(id_ex), .held_dest(held_dest)
    );

endmodule

// File: hdl/reg_file.sv
// Sixteen word register file
module reg_file #(
    parameter id_pkg::word_t SP_RESET = '1 // Top of stack after reset
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr_en,     // Write-back enable
    input  id_pkg::reg_idx_t wr_reg,
    input  id_pkg::word_t    wr_data,
    input  id_pkg::reg_idx_t rd_reg_1,
    input  id_pkg::reg_idx_t rd_reg_2,
    output id_pkg::word_t    rd_data_1,
    output id_pkg::word_t    rd_data_2
);

    id_pkg::word_t regs [16]; // r14 = DS, r15 = SP

    // Single write port, reset wins over write-back
    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
            regs[id_pkg::REG_SP] <= SP_RESET; // Stack starts at the top
        end else if (wr_en) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // Asynchronous reads
    // A write in this cycle is not visible until the next one
    assign rd_data_1 = regs[rd_reg_1];
    assign rd_data_2 = regs[rd_reg_2];

    // Stack pointer must come out of reset at the top of stack
    sp_after_reset: assert property (
        @(posedge clk) rst |=> (regs[id_pkg::REG_SP] == SP_RESET)
    ) else $error("reg_file: SP not loaded with SP_RESET after reset");

endmodule

// File: id_stage.f
hdl/id_pkg.sv
hdl/reg_file.sv
hdl/decode_ctrl.sv
hdl/hazard_detect.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
verification/tb_clock.sv
verification/id_checker.sv
verification/id_stage_tb.sv

// File: verification/id_checker.sv
// Decode stage response checker
module id_checker (
    input  logic           clk,
    input  logic           rst,
    input  logic           chk_en,      // A test was applied this cycle
    input  int             test_num,
    input  logic           exp_stall,
    input  id_pkg::id_ex_t exp_id_ex,
    input  logic           stall,       // DUT outputs
    input  id_pkg::id_ex_t id_ex,
    output int             pass_count,
    output int             fail_count,
    output int             done_count   // Tests finished, reset check included
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SETTLE = 10; // Past the edge, well before the next one

    int             cur_num;
    id_pkg::id_ex_t cur_exp;
    bit             test_ok;

    initial begin
        pass_count = 0;
        fail_count = 0;
        done_count = 0;
        $timeformat(-9, 0, " ns", 0);
    end

    // One field, zero extended to a word
    task automatic check_field(input int num, input string name, input logic [15:0] got,
                               input logic [15:0] exp, inout bit ok);
        if (got !== exp) begin
            $display("mismatch at %t: test %0d %s is %h, expected %h",
                     $time, num, name, got, exp);
            ok = 1'b0;
        end
    endtask

    task automatic check_id_ex(input int num, input id_pkg::id_ex_t got,
                               input id_pkg::id_ex_t exp, inout bit ok);
        check_field(num, "ctrl", got.ctrl, exp.ctrl, ok);
        check_field(num, "read_data_1", got.read_data_1, exp.read_data_1, ok);
        check_field(num, "read_data_2", got.read_data_2, exp.read_data_2, ok);
        check_field(num, "imm", got.imm, exp.imm, ok);
        check_field(num, "dest", got.dest, exp.dest, ok);
        check_field(num, "branch_cond", got.branch_cond, exp.branch_cond, ok);
        check_field(num, "call_target", got.call_target, exp.call_target, ok);
        check_field(num, "pc", got.pc, exp.pc, ok);
    endtask

    task automatic finish_test(input int num, input bit ok);
        if (ok) begin
            pass_count++;
            $display("test %0d passed", num);
        end else begin
            fail_count++;
            $display("test %0d failed", num);
        end
        done_count++;
    endtask

    // Test 0, ID/EX is a bubble once reset lets go
    initial begin : reset_check
        bit reset_ok;
        @(negedge rst);
        #SETTLE;
        reset_ok = 1'b1;
        check_id_ex(0, id_ex, '0, reset_ok);
        finish_test(0, reset_ok);
    end

    // Stall before the rising edge, ID/EX after it
    always begin : compare_loop
        @(negedge clk);
        #SETTLE;
        if (chk_en === 1'b1) begin
            cur_num = test_num;
            cur_exp = exp_id_ex;    // Held here, the driver moves on next cycle
            test_ok = 1'b1;
            check_field(cur_num, "stall", stall, exp_stall, test_ok);
            @(posedge clk);
            #SETTLE;
            check_id_ex(cur_num, id_ex, cur_exp, test_ok);
            finish_test(cur_num, test_ok);
        end
    end

endmodule

// File: verification/id_stage_tb.sv
// Decode stage testbench
module id_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam string DATA_FILE = "verification/id_stage_testdata.txt";
    localparam int    FIELDS    = 17; // Columns per data line

    // One data line, stimulus then expected response
    typedef struct packed {
        logic [31:0]       num;
        id_pkg::word_t     instr;
        id_pkg::word_t     pc;
        logic              wb_en;
        id_pkg::reg_idx_t  wb_reg;
        id_pkg::word_t     wb_data;
        id_pkg::dest_tag_t ex_mem_dest;
        id_pkg::dest_tag_t mem_wb_dest;
        logic              stall;
        id_pkg::id_ex_t    id_ex;
    } test_vec_t;

    logic              clk;
    logic              rst;
    id_pkg::word_t     instr;
    id_pkg::word_t     pc;
    logic              wb_en;
    id_pkg::reg_idx_t  wb_reg;
    id_pkg::word_t     wb_data;
    id_pkg::dest_tag_t ex_mem_dest;
    id_pkg::dest_tag_t mem_wb_dest;
    id_pkg::id_ex_t    id_ex;
    logic              stall;

    logic              chk_en;      // To the checker
    int                test_num;
    logic              exp_stall;
    id_pkg::id_ex_t    exp_id_ex;
    int                pass_count;
    int                fail_count;
    int                done_count;

    test_vec_t         tests[$];
    bit                load_ok;

    tb_clock #(.PERIOD(100), .RESET_CYCLES(5)) u_clock (.clk(clk), .rst(rst));

    id_stage uut (
        .clk(clk), .rst(rst), .instr(instr), .pc(pc),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
        .ex_mem_dest(ex_mem_dest), .mem_wb_dest(mem_wb_dest),
        .id_ex(id_ex), .stall(stall)
    );

    id_checker u_checker (
        .clk(clk), .rst(rst), .chk_en(chk_en), .test_num(test_num),
        .exp_stall(exp_stall), .exp_id_ex(exp_id_ex),
        .stall(stall), .id_ex(id_ex),
        .pass_count(pass_count), .fail_count(fail_count), .done_count(done_count)
    );

    // Idle bus, fetch sends a no-op
    task automatic idle_inputs();
        instr       = 16'hf000;
        pc          = '0;
        wb_en       = 1'b0;
        wb_reg      = '0;
        wb_data     = '0;
        ex_mem_dest = '0;
        mem_wb_dest = '0;
        chk_en      = 1'b0;
        test_num    = 0;
        exp_stall   = 1'b0;
        exp_id_ex   = '0;
    endtask

    task automatic load_tests(output bit ok);
        int          fd;
        int          count;
        string       line;
        logic [31:0] f [FIELDS];
        test_vec_t   v;
        ok = 1'b1;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open test data file %s", DATA_FILE);
            ok = 1'b0;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line[0] == "#") continue; // Column notes
                count = $sscanf(line, "%d %h %h %h %h %h %h %h %h %b %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                                f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                if (count == FIELDS) begin
                    v.num               = f[0];
                    v.instr             = f[1][15:0];
                    v.pc                = f[2][15:0];
                    v.wb_en             = f[3][0];
                    v.wb_reg            = f[4][3:0];
                    v.wb_data           = f[5][15:0];
                    v.ex_mem_dest       = f[6][4:0];
                    v.mem_wb_dest       = f[7][4:0];
                    v.stall             = f[8][0];
                    v.id_ex.ctrl        = f[9][9:0];  // Written in binary
                    v.id_ex.read_data_1 = f[10][15:0];
                    v.id_ex.read_data_2 = f[11][15:0];
                    v.id_ex.imm         = f[12][15:0];
                    v.id_ex.dest        = f[13][4:0];
                    v.id_ex.branch_cond = f[14][2:0];
                    v.id_ex.call_target = f[15][11:0];
                    v.id_ex.pc          = f[16][15:0];
                    tests.push_back(v);
                end else if (count > 0) begin
                    $display("Malformed test data line: %s", line);
                    ok = 1'b0;
                end
            end
            $fclose(fd);
            if (tests.size() == 0) begin
                $display("Test data file holds no tests");
                ok = 1'b0;
            end
        end
    endtask

    task automatic apply_test(input test_vec_t v);
        instr       = v.instr;
        pc          = v.pc;
        wb_en       = v.wb_en;
        wb_reg      = v.wb_reg;
        wb_data     = v.wb_data;
        ex_mem_dest = v.ex_mem_dest;
        mem_wb_dest = v.mem_wb_dest;
        test_num    = v.num;
        exp_stall   = v.stall;
        exp_id_ex   = v.id_ex;
        chk_en      = 1'b1;
    endtask

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not complete", cycles);
        $display("ERRORS FOUND");
        $finish;
    endtask

    initial begin
        idle_inputs();
        load_tests(load_ok);
        if (!load_ok) begin
            $display("No tests were run");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            fork
                watchdog(tests.size() * 2 + 20); // Reset covered by the margin
            join_none
            @(negedge rst);
            foreach (tests[i]) begin
                @(negedge clk);
                apply_test(tests[i]);
            end
            @(negedge clk);
            idle_inputs();
            wait (done_count == tests.size() + 1); // Plus the reset check
            $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

// File: verification/id_stage_testdata.txt
# num instr pc wb_en wb_reg wb_data ex_mem_dest mem_wb_dest, then expected stall ctrl(binary) rd1 rd2 imm dest branch_cond call_target pc
# dest tags are {valid, idx} in hex, ctrl bits run mem_to_reg reg_to_mem reg_write alu_src alu_op[2:0] branch call ret
1 8123 0010 0 0 0000 00 00 0 0010001010 ffff 0000 0001 1f 1 123 0010
2 f000 0012 1 2 1234 00 00 0 0000000000 0000 0000 0000 00 0 000 0012
3 aa5c 0014 1 3 00a5 00 00 0 0000000000 0000 0000 0000 00 2 a5c 0014
4 0123 0016 1 e 1000 00 00 0 0010000000 1234 00a5 0000 11 1 123 0016
5 17e2 0018 0 0 0000 00 00 0 0010001000 1000 1234 0000 17 7 7e2 0018
6 482c 001a 0 0 0000 00 00 0 0011000000 1234 0000 fffc 18 0 82c 001a
7 5980 001c 0 0 0000 00 00 0 1011000000 1000 0000 ff80 19 1 980 001c
8 62f0 001e 0 0 0000 00 00 0 0101000000 1000 1234 fff0 00 2 2f0 001e
9 2a23 0020 0 0 0000 00 00 0 0010010000 1234 00a5 0000 1a 2 a23 0020
10 7385 0022 0 0 0000 00 00 0 0000000100 0000 0000 ff85 00 3 385 0022
11 9000 0024 0 0 0000 00 00 0 0010000001 ffff 0000 0001 1f 0 000 0024
12 3b23 0026 0 0 0000 13 00 1 0000000000 0000 0000 0000 00 0 000 0000
13 3b23 0026 0 0 0000 00 12 1 0000000000 0000 0000 0000 00 0 000 0000
14 3b23 0026 0 0 0000 03 02 0 0010011000 1234 00a5 0000 1b 3 b23 0026
15 0cb2 0028 0 0 0000 00 00 1 0000000000 0000 0000 0000 00 0 000 0000
16 0cb2 0028 0 0 0000 1b 00 1 0000000000 0000 0000 0000 00 0 000 0000
17 0cb2 0028 1 b 0bee 00 1b 1 0000000000 0000 0000 0000 00 0 000 0000
18 0cb2 0028 0 0 0000 00 00 0 0010000000 0bee 1234 0000 1c 4 cb2 0028
19 6c00 002a 0 0 0000 00 00 1 0000000000 0000 0000 0000 00 0 000 0000
20 6c00 002a 0 0 0000 00 00 0 0101000000 1000 0000 0000 00 4 c00 002a
21 4d27 002c 0 0 0000 00 00 0 0011000000 1234 0000 0007 1d 5 d27 002c
22 f000 002e 0 0 0000 12 1e 0 0000000000 0000 0000 0000 00 0 000 002e

// File: verification/tb_clock.sv
// Testbench clock and reset
module tb_clock #(
    parameter int PERIOD       = 100, // ns
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released on a falling edge like all other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule
